// File: verilog/fc_data_pkg.sv
//////////////////////////////////////////////////////////////////////
// data widths, lane count and requantize constants
// lane and accumulator types, stream word union
//////////////////////////////////////////////////////////////////////

package fc_data_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes

  localparam int LANES      = 4;              // output neurons, bytes per word
  localparam int BYTE_W     = 8;              // int8 operands
  localparam int WORD_W     = LANES * BYTE_W; // stream word, 32 bits
  localparam int ACC_W      = 28;             // signed accumulator

  //////////////////////////////////////////////////////////////////////
  // fixed point

  localparam int FRAC_SHIFT = 6;    // right shift after rectify
  localparam int OUT_MAX    = 127;  // saturation ceiling

  // multiplier depth, accumulate stage not counted
  localparam int MUL_STAGES = 3;

  typedef logic signed [BYTE_W-1:0] lane_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  // one stream word, seen raw or as four signed bytes
  // lane 0 sits in the lowest byte
  // feature word  -> four consecutive features
  // weight word   -> weights of one feature for neurons 0..3
  // bias / result -> neurons 0..3
  typedef union packed {
    logic [WORD_W-1:0]      raw;
    lane_t [LANES-1:0]      lanes;
  } stream_word_u;

endpackage

// File: verilog/fc_ctrl_pkg.sv
//////////////////////////////////////////////////////////////////////
// load command codes
// sequencer state encoding
//////////////////////////////////////////////////////////////////////

package fc_ctrl_pkg;

  // command sampled with fc_start
  typedef enum logic [1:0] {
    CMD_NONE        = 2'd0,
    CMD_LOAD_FEAT   = 2'd1,  // N/4 words
    CMD_LOAD_BIAS   = 2'd2,  // one word
    CMD_LOAD_WEIGHT = 2'd3   // N words, then the run starts
  } fc_cmd_e;

  // processing control
  typedef enum logic [1:0] {
    SEQ_IDLE   = 2'd0,
    SEQ_ISSUE  = 2'd1,  // one product per cycle
    SEQ_DRAIN  = 2'd2,  // multiplier pipeline empties
    SEQ_RESULT = 2'd3   // accumulators handed over
  } seq_state_e;

endpackage

// File: verilog/fc_mac_pe.sv
//////////////////////////////////////////////////////////////////////
// signed int8 multiply-accumulate PE
// magnitude / partial product / sign pipeline, then accumulate
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module fc_mac_pe
  import fc_data_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,
  input  logic  issue,
  input  logic  first,
  input  lane_t a,
  input  lane_t b,
  output acc_t  acc
);

  localparam int PROD_W = 2 * BYTE_W;

  logic [BYTE_W-1:0]        mag_a, mag_b;   // stage 1
  logic                     sign_s1, sign_s2;
  logic [PROD_W-1:0]        pp_sum;
  logic [PROD_W-1:0]        prod_mag;       // stage 2
  logic signed [PROD_W-1:0] prod;           // stage 3
  logic                     v_s1, v_s2, v_s3;
  logic                     f_s1, f_s2, f_s3;

  // shift-and-add over the magnitude bits
  always_comb begin
    pp_sum = '0;
    for (int i = 0; i < BYTE_W; i++)
      if (mag_b[i])
        pp_sum = pp_sum + ({{BYTE_W{1'b0}}, mag_a} << i);
  end

  // valid and first ride along with the data
  always_ff @(posedge clk) begin
    if (!rstn) begin
      v_s1 <= 1'b0;
      v_s2 <= 1'b0;
      v_s3 <= 1'b0;
      f_s1 <= 1'b0;
      f_s2 <= 1'b0;
      f_s3 <= 1'b0;
    end else begin
      v_s1 <= issue;
      f_s1 <= first;
      v_s2 <= v_s1;
      f_s2 <= f_s1;
      v_s3 <= v_s2;
      f_s3 <= f_s2;
    end
  end

  always_ff @(posedge clk) begin
    mag_a    <= a[BYTE_W-1] ? ~a + 1'b1 : a;   // -128 gives 128 unsigned
    mag_b    <= b[BYTE_W-1] ? ~b + 1'b1 : b;
    sign_s1  <= a[BYTE_W-1] ^ b[BYTE_W-1];
    prod_mag <= pp_sum;
    sign_s2  <= sign_s1;
    prod     <= sign_s2 ? -$signed(prod_mag) : $signed(prod_mag);
    if (v_s3)
      acc <= f_s3 ? acc_t'(prod) : acc + acc_t'(prod);   // first loads
  end

endmodule

// File: verilog/fc_loader.sv
//////////////////////////////////////////////////////////////////////
// input side of the FC engine
// command decode, word counting, feature and weight memories,
// bias register, run start pulse
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module fc_loader
  import fc_data_pkg::*, fc_ctrl_pkg::*;
#(
  parameter int MAX_FEATURES = 256
) (
  input  logic                                    clk,
  input  logic                                    rstn,
  input  fc_cmd_e                                 command,
  input  logic                                    fc_start,
  input  logic [$clog2(MAX_FEATURES+1)-1:0]       size,
  input  logic                                    s_valid,
  input  stream_word_u                            s_data,
  output logic                                    s_ready,
  input  logic                                    seq_busy,
  input  logic                                    m_valid,
  input  logic [$clog2(MAX_FEATURES/LANES)-1:0]   feat_addr,
  input  logic [$clog2(MAX_FEATURES)-1:0]         weight_addr,
  output stream_word_u                            feat_word,
  output stream_word_u                            weight_word,
  output stream_word_u                            bias_word,
  output logic [$clog2(MAX_FEATURES+1)-1:0]       num_features,
  output logic                                    run_start,
  output logic                                    feat_done,
  output logic                                    bias_done,
  output logic                                    weight_done
);

  localparam int CNT_W = $clog2(MAX_FEATURES + 1);
  localparam int FA_W  = $clog2(MAX_FEATURES / LANES);
  localparam int WA_W  = $clog2(MAX_FEATURES);

  fc_cmd_e          cmd_q;
  logic [CNT_W-1:0] size_q;
  logic [CNT_W-1:0] word_cnt;
  logic [CNT_W-1:0] word_target;
  logic             xfer;
  logic             last_word;
  logic             start_ok;

  stream_word_u     feat_mem   [MAX_FEATURES/LANES];
  stream_word_u     weight_mem [MAX_FEATURES];

  assign xfer      = s_valid && s_ready;
  assign last_word = xfer && (word_cnt == word_target - 1'b1);

  // no new command while a run or its result is pending
  assign start_ok = fc_start && (command != CMD_NONE) &&
                    !seq_busy && !m_valid && !run_start;

  always_comb begin
    case (cmd_q)
      CMD_LOAD_FEAT: word_target = size_q >> 2;     // four features per word
      CMD_LOAD_BIAS: word_target = CNT_W'(1);
      default:       word_target = size_q;          // one word per feature
    endcase
  end

  assign num_features = size_q;

  //////////////////////////////////////////////////////////////////////
  // command and handshake control

  always_ff @(posedge clk) begin
    if (!rstn) begin
      s_ready     <= 1'b0;
      cmd_q       <= CMD_NONE;
      size_q      <= '0;
      word_cnt    <= '0;
      run_start   <= 1'b0;
      feat_done   <= 1'b0;
      bias_done   <= 1'b0;
      weight_done <= 1'b0;
    end else begin
      run_start <= 1'b0;
      if (!s_ready) begin
        if (start_ok) begin
          s_ready  <= 1'b1;
          cmd_q    <= command;
          word_cnt <= '0;
          if (command != CMD_LOAD_BIAS)
            size_q <= size;   // bias load keeps N
        end
      end else if (xfer) begin
        word_cnt <= word_cnt + 1'b1;
        if (last_word) begin
          s_ready <= 1'b0;
          case (cmd_q)
            CMD_LOAD_FEAT: feat_done <= 1'b1;
            CMD_LOAD_BIAS: bias_done <= 1'b1;
            CMD_LOAD_WEIGHT: begin
              weight_done <= 1'b1;
              run_start   <= 1'b1;
            end
            default: ;
          endcase
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memories, written on the handshake edge, one cycle read

  always_ff @(posedge clk) begin
    if (xfer && cmd_q == CMD_LOAD_FEAT)
      feat_mem[word_cnt[FA_W-1:0]] <= s_data;
    if (xfer && cmd_q == CMD_LOAD_WEIGHT)
      weight_mem[word_cnt[WA_W-1:0]] <= s_data;
    if (xfer && cmd_q == CMD_LOAD_BIAS)
      bias_word <= s_data;
    feat_word   <= feat_mem[feat_addr];
    weight_word <= weight_mem[weight_addr];
  end

endmodule

// File: verilog/fc_sequencer.sv
//////////////////////////////////////////////////////////////////////
// processing control of the FC engine
// walks feature and weight memories, feeds four MAC PEs,
// drains the pipeline and hands the sums to the output side
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module fc_sequencer
  import fc_data_pkg::*, fc_ctrl_pkg::*;
#(
  parameter int MAX_FEATURES = 256
) (
  input  logic                                    clk,
  input  logic                                    rstn,
  input  logic                                    run_start,
  input  logic [$clog2(MAX_FEATURES+1)-1:0]       num_features,
  output logic [$clog2(MAX_FEATURES/LANES)-1:0]   feat_addr,
  output logic [$clog2(MAX_FEATURES)-1:0]         weight_addr,
  input  stream_word_u                            feat_word,
  input  stream_word_u                            weight_word,
  output lane_t                                   feature_byte,
  output lane_t                                   weight_byte [LANES],
  output logic                                    issue,
  output logic                                    first,
  output acc_t                                    acc [LANES],
  output acc_t                                    acc_word [LANES],
  output logic                                    result_strobe,
  output logic                                    seq_busy
);

  localparam int CNT_W = $clog2(MAX_FEATURES + 1);
  localparam int WA_W  = $clog2(MAX_FEATURES);
  localparam int DR_W  = $clog2(MUL_STAGES + 1);
  localparam int SEL_W = $clog2(LANES);

  seq_state_e       state;
  logic [WA_W-1:0]  rd_idx;     // feature index on the memory address
  logic [CNT_W-1:0] issue_cnt;
  logic [DR_W-1:0]  drain_cnt;
  logic [SEL_W-1:0] byte_sel;   // follows rd_idx by the read latency

  assign weight_addr = rd_idx;
  assign feat_addr   = rd_idx[WA_W-1:SEL_W];

  assign issue = (state == SEQ_ISSUE);
  assign first = issue && (issue_cnt == '0);

  // feature broadcast, one weight lane per neuron
  assign feature_byte = feat_word.lanes[byte_sel];

  always_comb begin
    for (int i = 0; i < LANES; i++)
      weight_byte[i] = weight_word.lanes[i];
  end

  assign seq_busy = (state != SEQ_IDLE) || result_strobe;

  //////////////////////////////////////////////////////////////////////
  // FSM

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state         <= SEQ_IDLE;
      rd_idx        <= '0;
      issue_cnt     <= '0;
      drain_cnt     <= '0;
      result_strobe <= 1'b0;
    end else begin
      result_strobe <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          if (run_start) begin
            state     <= SEQ_ISSUE;
            rd_idx    <= WA_W'(1);   // word 0 already on its way
            issue_cnt <= '0;
          end
        end
        SEQ_ISSUE: begin
          rd_idx    <= rd_idx + 1'b1;
          issue_cnt <= issue_cnt + 1'b1;
          if (issue_cnt == num_features - 1'b1) begin
            state     <= SEQ_DRAIN;
            rd_idx    <= '0;
            drain_cnt <= '0;
          end
        end
        SEQ_DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == DR_W'(MUL_STAGES))
            state <= SEQ_RESULT;
        end
        SEQ_RESULT: begin
          result_strobe <= 1'b1;
          state         <= SEQ_IDLE;
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    byte_sel <= rd_idx[SEL_W-1:0];
    if (state == SEQ_RESULT)
      acc_word <= acc;   // final sums, held for the requantizer
  end

  // one PE per output neuron
  for (genvar i = 0; i < LANES; i++) begin : g_pe
    fc_mac_pe u_pe (
      .clk, .rstn, .issue, .first,
      .a   (feature_byte),
      .b   (weight_byte[i]),
      .acc (acc[i])
    );
  end

endmodule

// File: verilog/fc_requant.sv
//////////////////////////////////////////////////////////////////////
// output side of the FC engine
// bias add, ReLU, shift and saturate per lane, pack,
// hold under back-pressure, done pulse
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module fc_requant
  import fc_data_pkg::*;
(
  input  logic         clk,
  input  logic         rstn,
  input  logic         result_strobe,
  input  acc_t         acc_word [LANES],
  input  stream_word_u bias_word,
  output logic         m_valid,
  output stream_word_u m_data,
  input  logic         m_ready,
  output logic         fc_done
);

  stream_word_u packed_word;

  //////////////////////////////////////////////////////////////////////
  // per lane requantize

  always_comb begin
    acc_t sum;
    acc_t shifted;
    packed_word.raw = '0;
    for (int i = 0; i < LANES; i++) begin
      sum     = acc_word[i] + acc_t'(bias_word.lanes[i]);   // sign extended bias
      shifted = sum >>> FRAC_SHIFT;
      if (sum < 0)
        packed_word.lanes[i] = '0;                  // rectify
      else if (shifted > OUT_MAX)
        packed_word.lanes[i] = lane_t'(OUT_MAX);    // saturate
      else
        packed_word.lanes[i] = shifted[BYTE_W-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output handshake

  always_ff @(posedge clk) begin
    if (!rstn) begin
      m_valid <= 1'b0;
      fc_done <= 1'b0;
    end else begin
      fc_done <= m_valid && m_ready;   // one cycle after acceptance
      if (result_strobe)
        m_valid <= 1'b1;
      else if (m_ready)
        m_valid <= 1'b0;
    end
  end

  // word held until taken
  always_ff @(posedge clk) begin
    if (result_strobe)
      m_data <= packed_word;
  end

endmodule

// File: verilog/fc_top.sv
//////////////////////////////////////////////////////////////////////
// fully connected layer engine, top level
// loader -> sequencer with four PEs -> requantizer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module fc_top
  import fc_data_pkg::*, fc_ctrl_pkg::*;
#(
  parameter int MAX_FEATURES = 256
) (
  input  logic                                 clk,
  input  logic                                 rstn,
  input  fc_cmd_e                              command,
  input  logic                                 fc_start,
  input  logic [$clog2(MAX_FEATURES+1)-1:0]    size,
  input  logic                                 s_valid,
  input  stream_word_u                         s_data,
  output logic                                 s_ready,
  output logic                                 m_valid,
  output stream_word_u                         m_data,
  input  logic                                 m_ready,
  output logic                                 feat_done,
  output logic                                 bias_done,
  output logic                                 weight_done,
  output logic                                 fc_done
);

  localparam int CNT_W = $clog2(MAX_FEATURES + 1);
  localparam int FA_W  = $clog2(MAX_FEATURES / LANES);
  localparam int WA_W  = $clog2(MAX_FEATURES);

  logic [FA_W-1:0]  feat_addr;
  logic [WA_W-1:0]  weight_addr;
  stream_word_u     feat_word;
  stream_word_u     weight_word;
  stream_word_u     bias_word;
  logic [CNT_W-1:0] num_features;
  logic             run_start;
  logic             seq_busy;
  logic             result_strobe;
  acc_t             acc_word [LANES];

  fc_loader #(.MAX_FEATURES(MAX_FEATURES)) u_loader (
    .clk, .rstn, .command, .fc_start, .size,
    .s_valid, .s_data, .s_ready,
    .seq_busy, .m_valid,
    .feat_addr, .weight_addr, .feat_word, .weight_word, .bias_word,
    .num_features, .run_start,
    .feat_done, .bias_done, .weight_done
  );

  // PE-facing outputs are left open, they stay inside the sequencer
  fc_sequencer #(.MAX_FEATURES(MAX_FEATURES)) u_seq (
    .clk, .rstn, .run_start, .num_features,
    .feat_addr, .weight_addr, .feat_word, .weight_word,
    .feature_byte(), .weight_byte(), .issue(), .first(), .acc(),
    .acc_word, .result_strobe, .seq_busy
  );

  fc_requant u_requant (
    .clk, .rstn, .result_strobe, .acc_word, .bias_word,
    .m_valid, .m_data, .m_ready, .fc_done
  );

endmodule

// File: sim/fc_tb_assert.sv
//////////////////////////////////////////////////////////////////////
// concurrent checks on the FC engine ports, bound into fc_top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module fc_tb_assert
  import fc_data_pkg::*;
(
  input logic         clk,
  input logic         rstn,
  input logic         s_ready,
  input logic         m_valid,
  input logic         m_ready,
  input stream_word_u m_data,
  input logic         fc_done
);

  // stalled output word stays put
  a_hold: assert property (@(posedge clk) disable iff (!rstn)
    m_valid && !m_ready |=> m_valid && $stable(m_data))
    else $error("output word changed or dropped while stalled");

  a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
    fc_done |=> !fc_done)   // single cycle
    else $error("fc_done longer than one cycle");

  // sync reset, outputs low one edge later
  a_reset: assert property (@(posedge clk) !rstn |=> !s_ready && !m_valid)
    else $error("s_ready or m_valid high during reset");

endmodule

bind fc_top fc_tb_assert u_assert (
  .clk, .rstn, .s_ready, .m_valid, .m_ready, .m_data, .fc_done
);

// File: sim/fc_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the FC engine
// random loads, reference model, result and timing checks, run limit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module fc_tb
  import fc_data_pkg::*, fc_ctrl_pkg::*;
();

  localparam int MAX_FEATURES   = 256;
  localparam int RUNS           = 20;
  localparam int MAX_N          = 64;
  localparam int TIMEOUT_CYCLES = RUNS * (2 * MAX_N + 40) * 2;   // doubled for stalls

  logic                              clk;
  logic                              rstn;
  fc_cmd_e                           command;
  logic                              fc_start;
  logic [$clog2(MAX_FEATURES+1)-1:0] size;
  logic                              s_valid;
  stream_word_u                      s_data;
  logic                              s_ready;
  logic                              m_valid;
  stream_word_u                      m_data;
  logic                              m_ready;
  logic                              feat_done;
  logic                              bias_done;
  logic                              weight_done;
  logic                              fc_done;

  integer      seed;
  int unsigned cycle_cnt = 0;
  int          checks;
  int          errors;

  lane_t       feat  [MAX_N];
  lane_t       wgt   [MAX_N][LANES];
  lane_t       bias  [LANES];
  logic [31:0] words [MAX_N];   // words of the current load command

  fc_top #(.MAX_FEATURES(MAX_FEATURES)) dut (
    .clk, .rstn, .command, .fc_start, .size,
    .s_valid, .s_data, .s_ready,
    .m_valid, .m_data, .m_ready,
    .feat_done, .bias_done, .weight_done, .fc_done
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout, the engine made no progress within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers

  task automatic tick();
    @(posedge clk);
    #1;   // drive point 1 ns after the edge
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  // dot product, bias, ReLU, shift, clamp
  function automatic logic [31:0] expected_word(input int n);
    int          sum;
    int          q;
    logic [31:0] word;
    word = '0;
    for (int l = 0; l < LANES; l++) begin
      sum = bias[l];
      for (int j = 0; j < n; j++)
        sum += feat[j] * wgt[j][l];
      if (sum < 0)
        q = 0;
      else
        q = sum >>> FRAC_SHIFT;
      if (q > OUT_MAX)
        q = OUT_MAX;
      word[8*l +: 8] = q[7:0];
    end
    return word;
  endfunction

  // one load command of count words with random s_valid gaps
  task automatic load_words(input fc_cmd_e cmd, input int count, input string name,
                            output int unsigned last_hs);
    int   idx;
    logic rdy;
    idx      = 0;
    last_hs  = 0;
    compare({name, " s_ready before start"}, 0, s_ready);
    command  = cmd;
    fc_start = 1'b1;
    tick();
    fc_start = 1'b0;
    command  = CMD_NONE;
    while (idx < count) begin
      rdy = s_ready;
      compare({name, " s_ready"}, 1, rdy);
      s_valid    = ($random(seed) & 3) != 0;
      s_data.raw = words[idx];
      if (s_valid && rdy)
        last_hs = cycle_cnt;   // handshake cycle
      tick();
      if (s_valid && rdy)
        idx++;
    end
    s_valid = 1'b0;
    compare({name, " s_ready after last word"}, 0, s_ready);
  endtask

  //////////////////////////////////////////////////////////////////////
  // one run with loads, stray starts, latency and result under stalls

  task automatic run_test(input int r);
    int          n;
    int          stray_at;
    int          waited;
    int unsigned hs;
    logic [31:0] exp;
    logic [31:0] first_word;
    logic        accepted;
    string       tag;
    tag = $sformatf("run %0d", r);
    n   = 4 * (1 + ($unsigned($random(seed)) % (MAX_N / 4)));
    size = n;
    for (int j = 0; j < n; j++) begin
      feat[j] = lane_t'($random(seed));
      for (int l = 0; l < LANES; l++)
        wgt[j][l] = lane_t'($random(seed));
    end
    for (int l = 0; l < LANES; l++)
      bias[l] = lane_t'($random(seed));
    exp = expected_word(n);

    for (int w = 0; w < n / 4; w++)
      words[w] = {feat[4*w+3], feat[4*w+2], feat[4*w+1], feat[4*w]};   // lowest byte first
    load_words(CMD_LOAD_FEAT, n / 4, {tag, " feature load"}, hs);
    compare({tag, " feat_done"}, 1, feat_done);
    words[0] = {bias[3], bias[2], bias[1], bias[0]};
    load_words(CMD_LOAD_BIAS, 1, {tag, " bias load"}, hs);
    compare({tag, " bias_done"}, 1, bias_done);
    for (int j = 0; j < n; j++)
      words[j] = {wgt[j][3], wgt[j][2], wgt[j][1], wgt[j][0]};
    load_words(CMD_LOAD_WEIGHT, n, {tag, " weight load"}, hs);
    compare({tag, " weight_done"}, 1, weight_done);

    // stray start somewhere inside the run
    stray_at = $unsigned($random(seed)) % (n + MUL_STAGES + 4);   // up to the result strobe
    waited   = 0;
    command  = CMD_LOAD_FEAT;
    while (!m_valid) begin
      compare({tag, " s_ready during run"}, 0, s_ready);
      compare({tag, " fc_done during run"}, 0, fc_done);
      fc_start = (waited == stray_at);
      m_ready  = $random(seed) & 1;
      tick();
      waited++;
    end
    fc_start = 1'b0;
    compare({tag, " m_valid latency"}, n + MUL_STAGES + 5, cycle_cnt - hs);

    first_word = m_data.raw;
    compare({tag, " result word"}, exp, first_word);
    accepted = 1'b0;
    while (!accepted) begin
      compare({tag, " m_valid held"}, 1, m_valid);
      compare({tag, " held word"}, first_word, m_data.raw);
      compare({tag, " s_ready while output pending"}, 0, s_ready);
      compare({tag, " fc_done before accept"}, 0, fc_done);
      fc_start = $random(seed) & 1;          // stray start while the word is pending
      m_ready  = ($random(seed) & 3) == 0;   // mostly stalled
      accepted = m_ready;
      tick();
    end
    fc_start = 1'b0;
    command  = CMD_NONE;
    m_ready  = 1'b0;
    compare({tag, " m_valid after accept"}, 0, m_valid);
    compare({tag, " fc_done pulse"}, 1, fc_done);
    tick();
    compare({tag, " fc_done width"}, 0, fc_done);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    seed       = 32'h2ff78591;
    clk        = 1'b0;
    rstn       = 1'b0;
    checks     = 0;
    errors     = 0;
    command    = CMD_NONE;
    fc_start   = 1'b0;
    size       = '0;
    s_valid    = 1'b0;
    s_data.raw = '0;
    m_ready    = 1'b0;
    repeat (8) tick();
    rstn = 1'b1;

    compare("reset s_ready", 0, s_ready);
    compare("reset m_valid", 0, m_valid);
    compare("reset fc_done", 0, fc_done);
    compare("reset feat_done", 0, feat_done);
    compare("reset bias_done", 0, bias_done);
    compare("reset weight_done", 0, weight_done);

    for (int r = 0; r < RUNS; r++)
      run_test(r);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// File: flist.f
verilog/fc_data_pkg.sv
verilog/fc_ctrl_pkg.sv
verilog/fc_mac_pe.sv
verilog/fc_loader.sv
verilog/fc_sequencer.sv
verilog/fc_requant.sv
verilog/fc_top.sv
sim/fc_tb_assert.sv
sim/fc_tb.sv
